//--- hdl/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Core sizing

// Data path and address width in bits
`define CPU_WORD_W 16

// Architectural registers, R0 hardwired to zero
`define CPU_REG_CNT 16

// Program memory depth in 16-bit words
`define CPU_PROG_DEPTH 256

// Bytes per instruction
// PC is a byte address, so each fetch moves it by this amount
`define CPU_PC_STEP 2

`endif

//--- hdl/types_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package types_pkg;

	// Address and PC word
	typedef logic [`CPU_WORD_W-1:0] uword;

	// Data word
	typedef logic [`CPU_WORD_W-1:0] word_16;

	// Register index
	typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_addr_t;

	// Opcodes in bits 15:12
	typedef enum logic [3:0] {
		ADD  = 4'h0,
		SUB  = 4'h1,
		AND  = 4'h2,
		OR   = 4'h3,
		XOR  = 4'h4,
		SHL  = 4'h5,
		SHR  = 4'h6,
		LDI  = 4'h7,
		SKZ  = 4'h8,
		JMP  = 4'h9,
		HALT = 4'hf
	} opcode_e;

	// Instruction word layout, MSB first
	typedef struct packed {
		opcode_e   op;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
	} instr_t;

	// Sequencer states
	typedef enum logic [2:0] {
		FETCH,
		READ,
		EXEC,
		WBACK,
		HALTED
	} state_e;

endpackage

`default_nettype wire

//--- hdl/alu_pkg.sv
`default_nettype none

package alu_pkg;

	// ALU operation select
	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SHL,
		SHR,
		// Operand b straight to the result
		PASSB
	} control_e;

	// Operand pair
	typedef struct packed {
		types_pkg::word_16 a;
		types_pkg::word_16 b;
	} in_t;

	// Status flags
	// carry and overflow only meaningful after ADD or SUB
	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
		logic overflow;
	} status_t;

endpackage

`default_nettype wire

//--- hdl/rf_if.sv
`timescale 1ns/10ps
`default_nettype none

interface rf_if;

	// Operand read addresses
	types_pkg::reg_addr_t ra1;
	types_pkg::reg_addr_t ra2;

	// Operand read data
	types_pkg::word_16 rd1;
	types_pkg::word_16 rd2;

	// Write port
	logic we;
	types_pkg::reg_addr_t wa;
	types_pkg::word_16 wd;

	// Sequencer side, addresses and write control
	modport ctrl (
		output ra1,
		output ra2,
		output we,
		output wa
	);

	// Datapath side, operands toward the ALU
	modport dp (
		input rd1,
		input rd2
	);

	// Register file side
	modport regs (
		input  ra1,
		input  ra2,
		input  we,
		input  wa,
		input  wd,
		output rd1,
		output rd2
	);

endinterface

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module alu (
	input  alu_pkg::in_t      in,
	input  alu_pkg::control_e control,
	output alu_pkg::status_t  stat,
	output types_pkg::word_16 out
);
	localparam int MSB = `CPU_WORD_W - 1;

	// One extra bit for carry out or borrow
	logic [`CPU_WORD_W:0] sum;
	logic [`CPU_WORD_W:0] diff;
	// Shift amount, low nibble of b
	logic [3:0] shamt;

	assign sum = {1'b0, in.a} + {1'b0, in.b};
	assign diff = {1'b0, in.a} - {1'b0, in.b};
	assign shamt = in.b[3:0];

	always_comb begin
		out = '0;
		stat.carry = 1'b0;
		stat.overflow = 1'b0;
		case (control)
			alu_pkg::ADD: begin
				out = sum[MSB:0];
				stat.carry = sum[`CPU_WORD_W];
				// Same-sign operands, result sign flipped
				stat.overflow = (in.a[MSB] == in.b[MSB]) && (out[MSB] != in.a[MSB]);
			end
			alu_pkg::SUB: begin
				out = diff[MSB:0];
				// Borrow out of the top bit
				stat.carry = diff[`CPU_WORD_W];
				stat.overflow = (in.a[MSB] != in.b[MSB]) && (out[MSB] != in.a[MSB]);
			end
			alu_pkg::AND:   out = in.a & in.b;
			alu_pkg::OR:    out = in.a | in.b;
			alu_pkg::XOR:   out = in.a ^ in.b;
			alu_pkg::SHL:   out = in.a << shamt;
			// Logical shift, zero fill
			alu_pkg::SHR:   out = in.a >> shamt;
			alu_pkg::PASSB: out = in.b;
			default:        out = '0;
		endcase
		// Flags taken from the result for every operation
		stat.zero = (out == '0);
		stat.negative = out[MSB];
	end

endmodule

`default_nettype wire

//--- hdl/mem_register.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module mem_register (
	input  logic                 clk,
	input  logic                 rst,
	rf_if.regs                   rf,
	input  types_pkg::reg_addr_t dbg_addr,
	output types_pkg::word_16    dbg_data
);
	// Register array
	types_pkg::word_16 regs [`CPU_REG_CNT];

	// Shared read path, R0 forced to zero
	function automatic types_pkg::word_16 read_port(input types_pkg::reg_addr_t a);
		types_pkg::word_16 d;
		d = regs[a];
		if (a == '0) begin
			d = '0;
		end
		return d;
	endfunction

	// Write port
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (rf.we && (rf.wa != '0)) begin
			// Writes to R0 dropped
			regs[rf.wa] <= rf.wd;
		end
	end

	// Operand ports
	always_comb begin
		rf.rd1 = read_port(rf.ra1);
		rf.rd2 = read_port(rf.ra2);
	end

	// Debug port, same-cycle view
	always_comb begin
		dbg_data = read_port(dbg_addr);
	end

endmodule

`default_nettype wire

//--- hdl/mem_program.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module mem_program (
	input  logic              clk,
	input  types_pkg::uword   address,
	output types_pkg::word_16 data_out,
	input  logic              prog_we,
	input  logic [7:0]        prog_addr,
	input  types_pkg::word_16 prog_data
);
	// Word index width
	localparam int AW = $clog2(`CPU_PROG_DEPTH);

	types_pkg::word_16 mem [`CPU_PROG_DEPTH];

	// Load port
	// only used while the core is held in reset
	always_ff @(posedge clk) begin
		if (prog_we) begin
			mem[prog_addr] <= prog_data;
		end
	end

	// Byte address to word index, bit 0 dropped
	assign data_out = mem[address[AW:1]];

endmodule

`default_nettype wire

//--- hdl/pc_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module pc_counter (
	input  logic            clk,
	input  logic            rst,
	input  logic            pc_en,
	input  logic            skip,
	input  logic            jump,
	input  types_pkg::uword jump_target,
	output types_pkg::uword pc
);
	// One instruction forward
	localparam types_pkg::uword STEP = `CPU_PC_STEP;

	types_pkg::uword pc_next;

	// Next PC select
	always_comb begin
		if (jump) begin
			// Absolute, wins over skip
			pc_next = jump_target;
		end else if (skip) begin
			// Step over the following instruction
			pc_next = pc + STEP + STEP;
		end else begin
			pc_next = pc + STEP;
		end
	end

	// PC register
	// only moves on the writeback strobe
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else if (pc_en) begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

//--- hdl/control_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module control_fsm (
	input  logic              clk,
	input  logic              rst,
	input  types_pkg::word_16 instruction,
	input  alu_pkg::status_t  status,
	rf_if.ctrl                rf,
	output alu_pkg::control_e alucontrol,
	output logic              wd_sel,
	output types_pkg::word_16 imm,
	output logic              pc_en,
	output logic              skip,
	output logic              jump,
	output types_pkg::uword   jump_target,
	output logic              retire,
	output logic              halted,
	output types_pkg::state_e state
);
	types_pkg::instr_t ir;
	types_pkg::state_e state_next;
	logic zero_flag;
	logic is_alu;
	logic [7:0] imm8;

	// Instruction register, loaded in FETCH
	always_ff @(posedge clk) begin
		if (state == types_pkg::FETCH) begin
			ir <= types_pkg::instr_t'(instruction);
		end
	end

	assign is_alu = ir.op inside {types_pkg::ADD, types_pkg::SUB, types_pkg::AND,
		types_pkg::OR, types_pkg::XOR, types_pkg::SHL, types_pkg::SHR};

	// Zero flag of the last ALU instruction, sampled in EXEC
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			zero_flag <= 1'b0;
		end else if ((state == types_pkg::EXEC) && is_alu) begin
			zero_flag <= status.zero;
		end
	end

	// Sequencer
	always_comb begin
		case (state)
			types_pkg::FETCH: state_next = types_pkg::READ;
			types_pkg::READ:  state_next = types_pkg::EXEC;
			types_pkg::EXEC:  state_next = types_pkg::WBACK;
			// HALT still retires before stopping
			types_pkg::WBACK: begin
				state_next = (ir.op == types_pkg::HALT) ? types_pkg::HALTED : types_pkg::FETCH;
			end
			types_pkg::HALTED: state_next = types_pkg::HALTED;
			default:           state_next = types_pkg::FETCH;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= types_pkg::FETCH;
		end else begin
			state <= state_next;
		end
	end

	// Opcode to ALU operation
	always_comb begin
		case (ir.op)
			types_pkg::ADD: alucontrol = alu_pkg::ADD;
			types_pkg::SUB: alucontrol = alu_pkg::SUB;
			types_pkg::AND: alucontrol = alu_pkg::AND;
			types_pkg::OR:  alucontrol = alu_pkg::OR;
			types_pkg::XOR: alucontrol = alu_pkg::XOR;
			types_pkg::SHL: alucontrol = alu_pkg::SHL;
			types_pkg::SHR: alucontrol = alu_pkg::SHR;
			default:        alucontrol = alu_pkg::PASSB;
		endcase
	end

	// Register file addressing
	assign rf.ra1 = ir.rs1;
	assign rf.ra2 = ir.rs2;
	// LDI names its target in the rs1 field
	assign rf.wa = (ir.op == types_pkg::LDI) ? ir.rs1 : ir.rd;
	assign rf.we = (state == types_pkg::WBACK) && (is_alu || (ir.op == types_pkg::LDI));

	// Immediate, low byte zero extended
	assign imm8 = {ir.rs2, ir.rd};
	assign imm = types_pkg::word_16'(imm8);
	assign wd_sel = (ir.op == types_pkg::LDI);

	// PC update in WBACK, HALT leaves PC on itself
	assign pc_en = (state == types_pkg::WBACK) && (ir.op != types_pkg::HALT);
	assign skip = (ir.op == types_pkg::SKZ) && zero_flag;
	assign jump = (ir.op == types_pkg::JMP);
	// Word offset to byte address
	assign jump_target = types_pkg::uword'({imm8, 1'b0});

	assign retire = (state == types_pkg::WBACK);
	assign halted = (state == types_pkg::HALTED);

endmodule

`default_nettype wire

//--- hdl/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 prog_we,
	input  logic [7:0]           prog_addr,
	input  types_pkg::word_16    prog_data,
	input  types_pkg::reg_addr_t dbg_addr,
	output types_pkg::word_16    dbg_data,
	output types_pkg::uword      pc,
	output logic                 retire,
	output logic                 halted
);
	// Register file bundle
	rf_if rf ();

	types_pkg::word_16 instruction;
	alu_pkg::in_t alu_in;
	alu_pkg::control_e alucontrol;
	alu_pkg::status_t alu_stat;
	types_pkg::word_16 alu_out;
	types_pkg::word_16 imm;
	logic wd_sel;
	logic pc_en;
	logic skip;
	logic jump;
	types_pkg::uword jump_target;
	types_pkg::state_e state;

	// Operands straight from the register read ports
	assign alu_in.a = rf.rd1;
	assign alu_in.b = rf.rd2;

	// Write data, immediate for LDI
	assign rf.wd = wd_sel ? imm : alu_out;

	alu u_alu (
		.in      (alu_in),
		.control (alucontrol),
		.stat    (alu_stat),
		.out     (alu_out)
	);

	mem_register u_regs (
		.clk      (clk),
		.rst      (rst),
		.rf       (rf.regs),
		.dbg_addr (dbg_addr),
		.dbg_data (dbg_data)
	);

	mem_program u_prog (
		.clk       (clk),
		.address   (pc),
		.data_out  (instruction),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data)
	);

	pc_counter u_pc (
		.clk         (clk),
		.rst         (rst),
		.pc_en       (pc_en),
		.skip        (skip),
		.jump        (jump),
		.jump_target (jump_target),
		.pc          (pc)
	);

	control_fsm u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.status      (alu_stat),
		.rf          (rf.ctrl),
		.alucontrol  (alucontrol),
		.wd_sel      (wd_sel),
		.imm         (imm),
		.pc_en       (pc_en),
		.skip        (skip),
		.jump        (jump),
		.jump_target (jump_target),
		.retire      (retire),
		.halted      (halted),
		.state       (state)
	);

endmodule

`default_nettype wire

//--- tests/cpu_chk.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_chk (
	input logic              clk,
	input logic              rst,
	input logic              retire,
	input logic              halted,
	input types_pkg::uword   pc,
	input types_pkg::state_e state
);
	// Failure tally, read by the testbench at the end
	int fail_cnt = 0;

	// Four states per instruction, retire in the last one
	fetch_to_retire: assert property (@(posedge clk) disable iff (rst)
		(state == types_pkg::FETCH) |-> ##3 retire)
	else begin
		fail_cnt++;
		$error("retire did not follow FETCH after three cycles");
	end

	// No back to back retire
	retire_gap: assert property (@(posedge clk) disable iff (rst)
		retire |=> !retire [*3])
	else begin
		fail_cnt++;
		$error("retire pulsed again within four cycles");
	end

	// PC only moves on the edge that ends WBACK
	pc_after_retire: assert property (@(posedge clk) disable iff (rst)
		!$stable(pc) |-> $past(retire))
	else begin
		fail_cnt++;
		$error("pc changed outside the cycle after retire");
	end

	// Only reset leaves the halted state
	halt_sticky: assert property (@(posedge clk)
		$fell(halted) |-> rst)
	else begin
		fail_cnt++;
		$error("halted dropped without reset");
	end

	state_legal: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(state) && (state inside {types_pkg::FETCH, types_pkg::READ,
			types_pkg::EXEC, types_pkg::WBACK, types_pkg::HALTED}))
	else begin
		fail_cnt++;
		$error("control state unknown or out of range");
	end

endmodule

`default_nettype wire

//--- tests/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_tb;
	// Random ALU instructions between the fixed parts
	localparam int N_RAND = 200;
	// Load plus reset plus 4 cycles per instruction for about 300 instructions
	localparam int MAX_CYCLES = 2000;
	localparam types_pkg::opcode_e ALU_OPS [7] = '{types_pkg::ADD, types_pkg::SUB,
		types_pkg::AND, types_pkg::OR, types_pkg::XOR, types_pkg::SHL, types_pkg::SHR};

	logic clk;
	logic rst;
	logic prog_we;
	logic [7:0] prog_addr;
	types_pkg::word_16 prog_data;
	types_pkg::reg_addr_t dbg_addr;
	types_pkg::word_16 dbg_data;
	types_pkg::uword pc;
	logic retire;
	logic halted;

	integer seed = 32'hb90af7bf;
	int errors = 0;
	int cycles = 0;
	int total;
	// Checks start once the DUT has seen reset
	logic armed = 1'b0;

	// Program image, also read by the model
	types_pkg::word_16 prog_q [$];

	// Reference model state
	types_pkg::uword exp_pc;
	types_pkg::word_16 exp_regs [`CPU_REG_CNT];
	types_pkg::word_16 exp_dbg;
	logic exp_zero;
	logic exp_halted;
	logic [1:0] phase;
	logic exp_retire;

	cpu_top u_dut (
		.clk       (clk),
		.rst       (rst),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.dbg_addr  (dbg_addr),
		.dbg_data  (dbg_data),
		.pc        (pc),
		.retire    (retire),
		.halted    (halted)
	);

	bind cpu_top cpu_chk u_chk (
		.clk    (clk),
		.rst    (rst),
		.retire (retire),
		.halted (halted),
		.pc     (pc),
		.state  (state)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic types_pkg::word_16 make_rtype(types_pkg::opcode_e op,
		logic [3:0] s1, logic [3:0] s2, logic [3:0] d);
		return {op, s1, s2, d};
	endfunction

	function automatic types_pkg::word_16 make_imm(types_pkg::opcode_e op,
		logic [3:0] r, logic [7:0] imm);
		return {op, r, imm};
	endfunction

	task automatic build_program();
		logic [31:0] r;
		logic [7:0] tgt;
		// Seed every register, R0 included
		for (int k = 0; k < 16; k++) begin
			r = $random(seed);
			prog_q.push_back(make_imm(types_pkg::LDI, k[3:0], r[7:0]));
		end
		for (int k = 0; k < N_RAND; k++) begin
			r = $random(seed);
			prog_q.push_back(make_rtype(ALU_OPS[r[31:8] % 7], r[11:8], r[7:4], r[3:0]));
		end
		// Zero result, next LDI skipped
		prog_q.push_back(make_rtype(types_pkg::SUB, 4'd1, 4'd1, 4'd5));
		prog_q.push_back(make_imm(types_pkg::SKZ, 4'd0, 8'h00));
		prog_q.push_back(make_imm(types_pkg::LDI, 4'd6, 8'h5a));
		prog_q.push_back(make_imm(types_pkg::LDI, 4'd7, 8'h3c));
		// 1 - 2, nonzero, no skip
		prog_q.push_back(make_imm(types_pkg::LDI, 4'd2, 8'h01));
		prog_q.push_back(make_imm(types_pkg::LDI, 4'd3, 8'h02));
		prog_q.push_back(make_rtype(types_pkg::SUB, 4'd2, 4'd3, 4'd4));
		prog_q.push_back(make_imm(types_pkg::SKZ, 4'd0, 8'h00));
		prog_q.push_back(make_imm(types_pkg::LDI, 4'd8, 8'h77));
		// Forward jump over two loads
		tgt = prog_q.size() + 3;
		prog_q.push_back(make_imm(types_pkg::JMP, 4'd0, tgt));
		prog_q.push_back(make_imm(types_pkg::LDI, 4'd9, 8'hee));
		prog_q.push_back(make_imm(types_pkg::LDI, 4'd10, 8'hdd));
		prog_q.push_back(make_imm(types_pkg::LDI, 4'd11, 8'h42));
		prog_q.push_back(make_imm(types_pkg::HALT, 4'd0, 8'h00));
	endtask

	// One instruction, committed at the edge that ends WBACK
	task automatic step_model();
		types_pkg::word_16 ins;
		types_pkg::opcode_e op;
		types_pkg::word_16 a;
		types_pkg::word_16 b;
		types_pkg::word_16 res;
		types_pkg::uword next_pc;
		logic alu_op;
		ins = prog_q[exp_pc[8:1]];
		op = types_pkg::opcode_e'(ins[15:12]);
		a = exp_regs[ins[11:8]];
		b = exp_regs[ins[7:4]];
		res = '0;
		alu_op = 1'b1;
		next_pc = exp_pc + `CPU_PC_STEP;
		case (op)
			types_pkg::ADD: res = a + b;
			types_pkg::SUB: res = a - b;
			types_pkg::AND: res = a & b;
			types_pkg::OR:  res = a | b;
			types_pkg::XOR: res = a ^ b;
			types_pkg::SHL: res = a << b[3:0];
			types_pkg::SHR: res = a >> b[3:0];
			default:        alu_op = 1'b0;
		endcase
		if (alu_op) begin
			exp_zero <= (res == '0);
			if (ins[3:0] != 4'd0) begin
				exp_regs[ins[3:0]] <= res;
			end
		end
		if ((op == types_pkg::LDI) && (ins[11:8] != 4'd0)) begin
			exp_regs[ins[11:8]] <= {8'h00, ins[7:0]};
		end
		if ((op == types_pkg::SKZ) && exp_zero) begin
			next_pc = exp_pc + 2 * `CPU_PC_STEP;
		end
		if (op == types_pkg::JMP) begin
			next_pc = {7'b0, ins[7:0], 1'b0};
		end
		if (op == types_pkg::HALT) begin
			next_pc = exp_pc;
			exp_halted <= 1'b1;
		end
		exp_pc <= next_pc;
	endtask

	// Cycle position within the instruction
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			exp_pc <= '0;
			exp_zero <= 1'b0;
			exp_halted <= 1'b0;
			phase <= 2'd0;
			for (int i = 0; i < `CPU_REG_CNT; i++) begin
				exp_regs[i] <= '0;
			end
		end else if (!exp_halted) begin
			phase <= phase + 2'd1;
			if (phase == 2'd3) begin
				step_model();
			end
		end
	end

	assign exp_retire = (phase == 2'd3) && !exp_halted;
	assign exp_dbg = exp_regs[dbg_addr];

	task automatic log_mismatch(string name, types_pkg::word_16 expv, types_pkg::word_16 actv);
		errors = errors + 1;
		$display("[ERROR] %0t %s expected %h got %h", $time, name, expv, actv);
	endtask

	pc_match: assert property (@(posedge clk) disable iff (!armed) pc == exp_pc)
		else log_mismatch("pc", $sampled(exp_pc), $sampled(pc));
	dbg_match: assert property (@(posedge clk) disable iff (!armed) dbg_data == exp_dbg)
		else log_mismatch("dbg_data", $sampled(exp_dbg), $sampled(dbg_data));
	halted_match: assert property (@(posedge clk) disable iff (!armed) halted == exp_halted)
		else log_mismatch("halted", 16'($sampled(exp_halted)), 16'($sampled(halted)));
	retire_match: assert property (@(posedge clk) disable iff (!armed) retire == exp_retire)
		else log_mismatch("retire", 16'($sampled(exp_retire)), 16'($sampled(retire)));

	// Register sweep through the debug port, every cycle
	always @(negedge clk) begin
		dbg_addr <= dbg_addr + 1'b1;
	end

	// Watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: core not halted after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		dbg_addr = '0;
		build_program();
		@(negedge clk);
		armed = 1'b1;
		// Load while the core sits in reset
		for (int i = 0; i < prog_q.size(); i++) begin
			prog_we = 1'b1;
			prog_addr = i[7:0];
			prog_data = prog_q[i];
			@(negedge clk);
		end
		prog_we = 1'b0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		while (!halted) begin
			@(negedge clk);
		end
		// Two sweeps of the register file with the core stopped
		repeat (40) @(negedge clk);
		total = errors + u_dut.u_chk.fail_cnt;
		$display("Done: %0d model mismatches, %0d checker failures", errors,
			u_dut.u_chk.fail_cnt);
		if (total == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/types_pkg.sv
hdl/alu_pkg.sv
hdl/rf_if.sv
hdl/alu.sv
hdl/mem_register.sv
hdl/mem_program.sv
hdl/pc_counter.sv
hdl/control_fsm.sv
hdl/cpu_top.sv
tests/cpu_chk.sv
tests/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu16

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/types_pkg.sv
      - hdl/alu_pkg.sv
      - hdl/rf_if.sv
      - hdl/alu.sv
      - hdl/mem_register.sv
      - hdl/mem_program.sv
      - hdl/pc_counter.sv
      - hdl/control_fsm.sv
      - hdl/cpu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/cpu_chk.sv
      - tests/cpu_tb.sv
